// File: Makefile
VERILATOR ?= verilator
TOP       ?= fft_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -Wno-fatal
PASS_MSG  ?= TEST PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: list.f
+incdir+src
src/fft_pkg.sv
src/fft_butterfly.sv
src/fft_input_buffer.sv
src/fft_stage_engine.sv
src/fft_output_buffer.sv
src/fft_pease_top.sv
sim/fft_checker.sv
sim/fft_tb.sv

// File: sim/fft_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_macros.svh"

module fft_checker (
  input  logic             clk,
  input  logic             reset,
  input  fft_pkg::sample_t recv_msg [`FFT_N],
  input  logic             recv_val,
  input  logic             recv_rdy,
  input  fft_pkg::sample_t send_msg [`FFT_N],
  input  logic             send_val,
  input  logic             send_rdy,
  output int               errors,
  output int               frames_in,
  output int               frames_out
);

  // recv transfer to first send_val, starting from an empty pipeline
  localparam int LATENCY = 6;

  logic [32*`FFT_N-1:0] expected_q [$];
  logic [32*`FFT_N-1:0] expected;
  logic [32*`FFT_N-1:0] got;
  logic [32*`FFT_N-1:0] last_got;
  logic                 last_stalled;
  logic                 lat_armed;
  int                   lat_cnt;
  logic                 reset_seen;

  function automatic int rev_index(input int j);
    int r;
    r = 0;
    for (int b = 0; b < `FFT_LOG2N; b++) begin
      r = (r << 1) | ((j >> b) & 1);
    end
    return r;
  endfunction

  function automatic logic [32*`FFT_N-1:0] pack_frame(input fft_pkg::sample_t f [`FFT_N]);
    logic [32*`FFT_N-1:0] p;
    for (int j = 0; j < `FFT_N; j++) begin
      p[32*j +: 32] = f[j].raw;
    end
    return p;
  endfunction

  // bit-reversed load, then constant-geometry stages with truncating products
  function automatic logic [32*`FFT_N-1:0] fft_model(input logic [32*`FFT_N-1:0] x);
    logic signed [`FFT_W-1:0] re [`FFT_N];
    logic signed [`FFT_W-1:0] im [`FFT_N];
    logic signed [`FFT_W-1:0] nre [`FFT_N];
    logic signed [`FFT_W-1:0] nim [`FFT_N];
    logic signed [`FFT_W-1:0] tre;
    logic signed [`FFT_W-1:0] tim;
    logic [32*`FFT_N-1:0]     y;
    int                       k;
    int                       sh;
    int                       prr;
    int                       pii;
    int                       pri;
    int                       pir;
    for (int j = 0; j < `FFT_N; j++) begin
      re[rev_index(j)] = x[32*j +: 16];
      im[rev_index(j)] = x[32*j+16 +: 16];
    end
    for (int s = 0; s < `FFT_LOG2N; s++) begin
      sh = `FFT_LOG2N - 1 - s;
      for (int i = 0; i < `FFT_N/2; i++) begin
        k   = (i >> sh) << sh;
        prr = int'(re[2*i+1]) * int'(fft_pkg::twiddle_re[k]);
        pii = int'(im[2*i+1]) * int'(fft_pkg::twiddle_im[k]);
        pri = int'(re[2*i+1]) * int'(fft_pkg::twiddle_im[k]);
        pir = int'(im[2*i+1]) * int'(fft_pkg::twiddle_re[k]);
        tre = `FFT_W'((prr >>> `FFT_FRAC) - (pii >>> `FFT_FRAC));
        tim = `FFT_W'((pri >>> `FFT_FRAC) + (pir >>> `FFT_FRAC));
        // stride permutation with sums wrapping at 16 bits
        nre[i]            = re[2*i] + tre;
        nim[i]            = im[2*i] + tim;
        nre[i + `FFT_N/2] = re[2*i] - tre;
        nim[i + `FFT_N/2] = im[2*i] - tim;
      end
      re = nre;
      im = nim;
    end
    for (int j = 0; j < `FFT_N; j++) begin
      y[32*j +: 32] = {im[j], re[j]};
    end
    return y;
  endfunction

  // inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin
    if (reset) begin
      errors       = 0;
      frames_in    = 0;
      frames_out   = 0;
      last_stalled = 1'b0;
      lat_armed    = 1'b0;
      lat_cnt      = 0;
      reset_seen   = 1'b0;
    end else begin
      if (!reset_seen) begin
        if (recv_rdy !== 1'b1) begin
          $display("error recv_rdy after reset: got %h expected %h", recv_rdy, 1'b1);
          errors++;
        end
        if (send_val !== 1'b0) begin
          $display("error send_val after reset: got %h expected %h", send_val, 1'b0);
          errors++;
        end
        reset_seen = 1'b1;
      end
      got = pack_frame(send_msg);
      if (last_stalled) begin
        for (int j = 0; j < `FFT_N; j++) begin
          if (got[32*j +: 32] !== last_got[32*j +: 32]) begin
            $display("error send_msg[%0d] changed while stalled: was %h now %h",
                     j, last_got[32*j +: 32], got[32*j +: 32]);
            errors++;
          end
        end
      end
      if (lat_armed) begin
        lat_cnt++;
        if (send_val) begin
          if (lat_cnt != LATENCY) begin
            $display("error send_val latency: got %h expected %h", lat_cnt, LATENCY);
            errors++;
          end
          lat_armed = 1'b0;
        end
      end
      if (send_val && send_rdy) begin
        frames_out++;
        if (expected_q.size() == 0) begin
          $display("a frame came out of the DUT with no frame outstanding");
          errors++;
        end else begin
          expected = expected_q.pop_front();
          for (int j = 0; j < `FFT_N; j++) begin
            if (got[32*j +: 32] !== expected[32*j +: 32]) begin
              $display("error send_msg[%0d]: got %h expected %h",
                       j, got[32*j +: 32], expected[32*j +: 32]);
              errors++;
            end
          end
        end
      end
      if (recv_val && recv_rdy) begin
        // latency is fixed only when nothing else is inside
        if (expected_q.size() == 0) begin
          lat_armed = 1'b1;
          lat_cnt   = 0;
        end
        expected_q.push_back(fft_model(pack_frame(recv_msg)));
        frames_in++;
      end
      last_stalled = send_val && !send_rdy;
      last_got     = got;
    end
  end

endmodule

`default_nettype wire

// File: sim/fft_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_macros.svh"

module fft_tb;

  localparam int TIMEOUT = 200;

  logic             clk;
  logic             reset;
  fft_pkg::sample_t recv_msg [`FFT_N];
  logic             recv_val;
  logic             recv_rdy;
  fft_pkg::sample_t send_msg [`FFT_N];
  logic             send_val;
  logic             send_rdy;

  int   chk_errors;
  int   frames_in;
  int   frames_out;
  int   timeouts;
  logic feed_done;

  fft_pease_top dut0 (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

  fft_checker chk0 (
    .clk        (clk),
    .reset      (reset),
    .recv_msg   (recv_msg),
    .recv_val   (recv_val),
    .recv_rdy   (recv_rdy),
    .send_msg   (send_msg),
    .send_val   (send_val),
    .send_rdy   (send_rdy),
    .errors     (chk_errors),
    .frames_in  (frames_in),
    .frames_out (frames_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  // 2 ns past the next rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    timeouts++;
  endtask

  // hold the frame on recv until the DUT takes it
  task automatic send_frame(input logic [32*`FFT_N-1:0] f);
    int waited;
    waited = 0;
    for (int j = 0; j < `FFT_N; j++) begin
      recv_msg[j].raw = f[32*j +: 32];
    end
    recv_val = 1'b1;
    while (!recv_rdy && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (recv_rdy) begin
      next_cycle();
    end else begin
      report_timeout("recv_rdy");
    end
    recv_val = 1'b0;
  endtask

  function automatic logic [32*`FFT_N-1:0] random_frame(input bit full_range);
    logic [32*`FFT_N-1:0] f;
    logic [`FFT_W-1:0]    re;
    logic [`FFT_W-1:0]    im;
    for (int j = 0; j < `FFT_N; j++) begin
      if (full_range) begin
        re = `FFT_W'($urandom);
        im = `FFT_W'($urandom);
      end else begin
        // parts in -1000..1000
        re = `FFT_W'(int'($urandom_range(2000)) - 1000);
        im = `FFT_W'(int'($urandom_range(2000)) - 1000);
      end
      f[32*j +: 32] = {im, re};
    end
    return f;
  endfunction

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (frames_out != frames_in && waited < TIMEOUT) begin
      next_cycle();
      waited++;
    end
    if (frames_out != frames_in) begin
      report_timeout("all frames to leave the DUT");
    end
  endtask

  // input side should stay blocked once every buffer holds a frame
  task automatic wait_recv_blocked();
    int waited;
    int low_run;
    waited  = 0;
    low_run = 0;
    while (low_run < 10 && waited < TIMEOUT) begin
      low_run = recv_rdy ? 0 : low_run + 1;
      next_cycle();
      waited++;
    end
    if (low_run < 10) begin
      report_timeout("recv_rdy to stay low during a long output stall");
    end
  endtask

  // random stretches of send_rdy high or low
  task automatic drive_back_pressure();
    int len;
    while (!feed_done) begin
      send_rdy = 1'($urandom_range(1));
      len      = int'($urandom_range(8, 1));
      repeat (len) begin
        next_cycle();
      end
    end
    send_rdy = 1'b1;
  endtask

  initial begin
    void'($urandom(58217));
    reset     = 1'b1;
    recv_val  = 1'b0;
    send_rdy  = 1'b0;
    feed_done = 1'b0;
    timeouts  = 0;
    for (int j = 0; j < `FFT_N; j++) begin
      recv_msg[j].raw = '0;
    end
    repeat (5) @(posedge clk);
    #2;
    reset    = 1'b0;
    send_rdy = 1'b1;

    // impulse at sample 0
    send_frame({{(32*(`FFT_N-1)){1'b0}}, 16'd0, 16'd256});
    wait_drain();

    // one frame at a time, so every frame sees an empty pipeline
    repeat (20) begin
      send_frame(random_frame(1'b0));
      wait_drain();
    end

    fork
      begin
        repeat (20) send_frame(random_frame(1'b0));
        feed_done = 1'b1;
      end
      drive_back_pressure();
    join
    wait_drain();

    // output buffer, engine and input buffer all fill up
    send_rdy = 1'b0;
    repeat (3) send_frame(random_frame(1'b0));
    wait_recv_blocked();
    send_rdy = 1'b1;
    wait_drain();

    // extremes first, then random full range words
    send_frame({`FFT_N{32'h7fff_7fff}});
    send_frame({`FFT_N{32'h8000_8000}});
    repeat (10) send_frame(random_frame(1'b1));
    wait_drain();

    $display("errors %0d (checker %0d, timeouts %0d), frames in %0d, frames out %0d",
             chk_errors + timeouts, chk_errors, timeouts, frames_in, frames_out);
    if (chk_errors + timeouts == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/fft_butterfly.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_macros.svh"

module fft_butterfly (
  input  fft_pkg::sample_t         a,
  input  fft_pkg::sample_t         b,
  input  logic signed [`FFT_W-1:0] w_re,
  input  logic signed [`FFT_W-1:0] w_im,
  output fft_pkg::sample_t         c,
  output fft_pkg::sample_t         d
);

  // full width partial products of b*w
  logic signed [2*`FFT_W-1:0] p_rr;
  logic signed [2*`FFT_W-1:0] p_ii;
  logic signed [2*`FFT_W-1:0] p_ri;
  logic signed [2*`FFT_W-1:0] p_ir;
  logic signed [`FFT_W-1:0]   t_re;
  logic signed [`FFT_W-1:0]   t_im;

  assign p_rr = $signed(b.parts.re) * w_re;
  assign p_ii = $signed(b.parts.im) * w_im;
  assign p_ri = $signed(b.parts.re) * w_im;
  assign p_ir = $signed(b.parts.im) * w_re;

  // each product drops its fraction bits before the sum, toward minus infinity
  assign t_re = `FFT_W'((p_rr >>> `FFT_FRAC) - (p_ii >>> `FFT_FRAC));
  assign t_im = `FFT_W'((p_ri >>> `FFT_FRAC) + (p_ir >>> `FFT_FRAC));

  // sums wrap at FFT_W bits
  always_comb begin
    c.parts.re = a.parts.re + t_re;
    c.parts.im = a.parts.im + t_im;
    d.parts.re = a.parts.re - t_re;
    d.parts.im = a.parts.im - t_im;
  end

endmodule

`default_nettype wire

// File: src/fft_input_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_macros.svh"

module fft_input_buffer (
  input  logic             clk,
  input  logic             reset,
  input  fft_pkg::sample_t recv_msg [`FFT_N],
  input  logic             recv_val,
  input  logic             frame_take,
  output logic             recv_rdy,
  output logic             frame_val,
  output fft_pkg::sample_t frame [`FFT_N]
);

  logic             full;
  fft_pkg::sample_t held [`FFT_N];

  // mirror the index bits
  function automatic logic [`FFT_LOG2N-1:0] bitrev(input logic [`FFT_LOG2N-1:0] j);
    logic [`FFT_LOG2N-1:0] r;
    for (int b = 0; b < `FFT_LOG2N; b++) begin
      r[b] = j[`FFT_LOG2N-1-b];
    end
    return r;
  endfunction

  assign recv_rdy  = !full;
  assign frame_val = full;
  assign frame     = held;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (recv_val && recv_rdy) begin
      full <= 1'b1;
    end else if (frame_take) begin
      full <= 1'b0;
    end
  end

  // frame lands already in bit-reversed order
  always_ff @(posedge clk) begin
    if (recv_val && recv_rdy) begin
      for (int j = 0; j < `FFT_N; j++) begin
        held[bitrev(`FFT_LOG2N'(j))].raw <= recv_msg[j].raw;
      end
    end
  end

  // engine may only take a frame that is actually here
  a_take_when_full: assert property (
    @(posedge clk) disable iff (reset) frame_take |-> full
  );

endmodule

`default_nettype wire

// File: src/fft_macros.svh
`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// samples per frame
`define FFT_N 8

// number of butterfly stages, also the width of a sample index
`define FFT_LOG2N 3

// width of one real or imaginary part, two's complement
`define FFT_W 16

// fraction bits of samples and twiddles
`define FFT_FRAC 8

`endif

// File: src/fft_output_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_macros.svh"

module fft_output_buffer (
  input  logic             clk,
  input  logic             reset,
  input  logic             result_val,
  input  fft_pkg::sample_t result [`FFT_N],
  input  logic             send_rdy,
  output logic             result_rdy,
  output logic             send_val,
  output fft_pkg::sample_t send_msg [`FFT_N]
);

  logic             full;
  fft_pkg::sample_t held [`FFT_N];

  assign result_rdy = !full;
  assign send_val   = full;
  assign send_msg   = held;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (result_val) begin
      full <= 1'b1;
    end else if (send_val && send_rdy) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (result_val) begin
      for (int j = 0; j < `FFT_N; j++) begin
        held[j].raw <= result[j].raw;
      end
    end
  end

  // a stalled spectrum must not be overwritten by the engine
  for (genvar j = 0; j < `FFT_N; j++) begin : g_hold_chk
    a_send_hold: assert property (
      @(posedge clk) disable iff (reset)
      (send_val && !send_rdy) |=> $stable(send_msg[j].raw)
    );
  end

endmodule

`default_nettype wire

// File: src/fft_pease_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_macros.svh"

module fft_pease_top (
  input  logic             clk,
  input  logic             reset,
  input  fft_pkg::sample_t recv_msg [`FFT_N],
  input  logic             recv_val,
  output logic             recv_rdy,
  output fft_pkg::sample_t send_msg [`FFT_N],
  output logic             send_val,
  input  logic             send_rdy
);

  // input buffer to engine
  logic             frame_val;
  logic             frame_take;
  fft_pkg::sample_t frame [`FFT_N];

  // engine to output buffer
  logic             result_val;
  logic             result_rdy;
  fft_pkg::sample_t result [`FFT_N];

  fft_input_buffer in_buf (
    .clk        (clk),
    .reset      (reset),
    .recv_msg   (recv_msg),
    .recv_val   (recv_val),
    .frame_take (frame_take),
    .recv_rdy   (recv_rdy),
    .frame_val  (frame_val),
    .frame      (frame)
  );

  fft_stage_engine engine (
    .clk        (clk),
    .reset      (reset),
    .frame_val  (frame_val),
    .frame      (frame),
    .result_rdy (result_rdy),
    .frame_take (frame_take),
    .result_val (result_val),
    .result     (result)
  );

  fft_output_buffer out_buf (
    .clk        (clk),
    .reset      (reset),
    .result_val (result_val),
    .result     (result),
    .send_rdy   (send_rdy),
    .result_rdy (result_rdy),
    .send_val   (send_val),
    .send_msg   (send_msg)
  );

endmodule

`default_nettype wire

// File: src/fft_pkg.sv
`default_nettype none

`include "fft_macros.svh"

package fft_pkg;

  // one complex sample, imaginary part in the upper half
  typedef struct packed {
    logic signed [`FFT_W-1:0] im;
    logic signed [`FFT_W-1:0] re;
  } complex_t;

  // buffers move the raw word, the butterfly reads the parts
  typedef union packed {
    complex_t            parts;
    logic [2*`FFT_W-1:0] raw;
  } sample_t;

  // W8^k = cos(2*pi*k/8) - j*sin(2*pi*k/8), scaled by 2^FFT_FRAC
  localparam logic signed [`FFT_W-1:0] twiddle_re [`FFT_N/2] = '{
    `FFT_W'(256),
    `FFT_W'(181),
    `FFT_W'(0),
    `FFT_W'(-181)
  };

  localparam logic signed [`FFT_W-1:0] twiddle_im [`FFT_N/2] = '{
    `FFT_W'(0),
    `FFT_W'(-181),
    `FFT_W'(-256),
    `FFT_W'(-181)
  };

endpackage

`default_nettype wire

// File: src/fft_stage_engine.sv
`timescale 1ns/1ns
`default_nettype none

`include "fft_macros.svh"

module fft_stage_engine (
  input  logic             clk,
  input  logic             reset,
  input  logic             frame_val,
  input  fft_pkg::sample_t frame [`FFT_N],
  input  logic             result_rdy,
  output logic             frame_take,
  output logic             result_val,
  output fft_pkg::sample_t result [`FFT_N]
);

  // stage counter width and twiddle index width
  localparam int SW = $clog2(`FFT_LOG2N);
  localparam int KW = `FFT_LOG2N - 1;

  typedef enum logic [1:0] {
    IDLE,
    COMPUTE,
    DONE
  } state_e;

  state_e           state;
  logic [SW-1:0]    s;
  logic [KW-1:0]    tw_mask;
  fft_pkg::sample_t work [`FFT_N];
  fft_pkg::sample_t next_work [`FFT_N];

  assign frame_take = (state == IDLE) && frame_val;
  assign result_val = (state == DONE) && result_rdy;
  assign result     = work;

  // stage s keeps only the top s bits of the butterfly index
  assign tw_mask = {KW{1'b1}} << (KW - int'(s));

  // same bank every stage, outputs go through the stride permutation
  for (genvar i = 0; i < `FFT_N/2; i++) begin : g_bfly
    logic [KW-1:0]    k;
    fft_pkg::sample_t c;
    fft_pkg::sample_t d;

    assign k = KW'(i) & tw_mask;

    fft_butterfly bfly (
      .a    (work[2*i]),
      .b    (work[2*i+1]),
      .w_re (fft_pkg::twiddle_re[k]),
      .w_im (fft_pkg::twiddle_im[k]),
      .c    (c),
      .d    (d)
    );

    assign next_work[i]            = c;
    assign next_work[i + `FFT_N/2] = d;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      s     <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (frame_val) begin
            state <= COMPUTE;
          end
        end
        COMPUTE: begin
          if (s == SW'(`FFT_LOG2N - 1)) begin
            state <= DONE;
            s     <= '0;
          end else begin
            s <= s + 1'b1;
          end
        end
        DONE: begin
          // hand off only when the output buffer is empty
          if (result_rdy) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // working register
  always_ff @(posedge clk) begin
    if (frame_take) begin
      work <= frame;
    end else if (state == COMPUTE) begin
      work <= next_work;
    end
  end

  a_stage_range: assert property (
    @(posedge clk) disable iff (reset) s <= SW'(`FFT_LOG2N - 1)
  );

endmodule

`default_nettype wire
